/* build.f */
+incdir+include
rtl/regval_pkg.sv
rtl/dispatch_decode.sv
rtl/reg_track.sv
rtl/operand_lookup.sv
rtl/regval_top.sv
bench/regval_properties.sv
bench/regval_checker.sv
bench/regval_tb.sv

/* bench/regval_tb.sv */
// testbench of the scoreboard, driving LFSR stimulus into the DUT beside a model-based checker
`timescale 1ns/1ns
`include "regval_settings.svh"

module regval_tb;
	import regval_pkg::*;

	localparam int NUM_CYCLES = 4000;
	localparam logic [31:0] LFSR_SEED = 32'hbf1c0475;
	// x^32 + x^22 + x^2 + x + 1 in Galois form
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic      clk;
	logic      rst;
	slot_t     slots [`REGVAL_QSLOTS];
	commit_t   commits [`REGVAL_CPORTS];
	reg_mask_t livetarget;
	logic      branchmiss;
	reg_mask_t rf_v;
	reg_mask_t reg_is_valid;
	operand_t  operands [2*`REGVAL_QSLOTS];

	int error_count;
	int checked_count;
	int timeouts;
	int assert_fails;

	// random source and the tags recently handed to each register
	logic [31:0] lfsr_state;
	rob_tag_t    next_tag;
	rob_tag_t    last_tag [`REGVAL_AREGS];
	rob_tag_t    prev_tag [`REGVAL_AREGS];

	always #2 clk = ~clk;

	regval_top i_regval_top (.clk(clk), .rst(rst), .slots(slots), .commits(commits),
		.livetarget(livetarget), .branchmiss(branchmiss), .rf_v(rf_v),
		.reg_is_valid(reg_is_valid), .operands(operands));

	regval_checker i_regval_checker (.clk(clk), .rst(rst), .slots(slots), .commits(commits),
		.livetarget(livetarget), .branchmiss(branchmiss), .rf_v(rf_v),
		.reg_is_valid(reg_is_valid), .operands(operands), .error_count(error_count),
		.checked_count(checked_count));

	bind regval_top regval_properties i_regval_properties (.clk(clk), .rst(rst), .rf_v(rf_v),
		.reg_is_valid(reg_is_valid), .claims(claims));

	// ==========================================================================
	// random numbers
	// ==========================================================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// one LFSR step for every bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r          = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	// ==========================================================================
	// stimulus for one cycle, called right after a rising edge
	// ==========================================================================

	task automatic drive_cycle();
		logic       bm;
		logic [1:0] pick;
		slot_t      sl;
		commit_t    cm;
		// a branch miss in about one cycle of sixteen
		bm = (rand_bits(4) == 0);
		branchmiss <= bm;
		livetarget <= reg_mask_t'(rand_bits(`REGVAL_AREGS));
		// most commit ids come from the register's recent tags, so both
		// matching and stale results show up
		for (int p = 0; p < `REGVAL_CPORTS; p++) begin
			cm.v   = (rand_bits(1) != 0);
			cm.rfw = (rand_bits(2) != 0);
			cm.tgt = reg_idx_t'(rand_bits(`REGVAL_REG_W));
			pick   = 2'(rand_bits(2));
			if (pick < 2) begin
				cm.id = last_tag[cm.tgt];
			end else if (pick == 2) begin
				cm.id = prev_tag[cm.tgt];
			end else begin
				cm.id = rob_tag_t'(rand_bits(`REGVAL_TAG_W));
			end
			commits[p] <= cm;
		end
		for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
			sl.v   = (rand_bits(1) != 0);
			sl.rfw = (rand_bits(2) != 0);
			sl.rd  = reg_idx_t'(rand_bits(`REGVAL_REG_W));
			sl.rs1 = reg_idx_t'(rand_bits(`REGVAL_REG_W));
			sl.rs2 = reg_idx_t'(rand_bits(`REGVAL_REG_W));
			sl.tag = next_tag;
			next_tag++;
			if (sl.v && sl.rfw && !bm) begin
				prev_tag[sl.rd] = last_tag[sl.rd];
				last_tag[sl.rd] = sl.tag;
			end
			slots[s] <= sl;
		end
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial begin
		int waited;
		int target;
		clk        = 1'b0;
		rst        = 1'b1;
		branchmiss = 1'b0;
		livetarget = '0;
		for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
			slots[s] = '0;
		end
		for (int p = 0; p < `REGVAL_CPORTS; p++) begin
			commits[p] = '0;
		end
		for (int n = 0; n < `REGVAL_AREGS; n++) begin
			last_tag[n] = '0;
			prev_tag[n] = '0;
		end
		lfsr_state = LFSR_SEED;
		next_tag   = '0;
		timeouts   = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		waited = 0;
		while (rst !== 1'b0 && waited < 16) begin
			@(posedge clk);
			waited++;
		end
		if (rst !== 1'b0) begin
			$display("timeout while waiting for reset to be released");
			timeouts++;
		end else begin
			for (int c = 0; c < NUM_CYCLES; c++) begin
				@(posedge clk);
				drive_cycle();
			end
			// the last driven cycle is compared at the next falling edge
			target = checked_count + 1;
			waited = 0;
			while (checked_count < target && waited < 16) begin
				@(posedge clk);
				waited++;
			end
			if (checked_count < target) begin
				$display("timeout while waiting for the checker to reach the last cycle");
				timeouts++;
			end
		end
		assert_fails = i_regval_top.i_regval_properties.reset_fails +
			i_regval_top.i_regval_properties.claim_fails +
			i_regval_top.i_regval_properties.adv_fails;
		$display("regval_tb: %0d mismatches, %0d assertion failures, %0d timeouts in %0d cycles",
			error_count, assert_fails, timeouts, checked_count);
		if (error_count == 0 && assert_fails == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* bench/regval_checker.sv */
// reference model of the scoreboard that compares every DUT output once per cycle
`timescale 1ns/1ns
`include "regval_settings.svh"

module regval_checker (
	input  logic                  clk,
	input  logic                  rst,
	input  regval_pkg::slot_t     slots [`REGVAL_QSLOTS],
	input  regval_pkg::commit_t   commits [`REGVAL_CPORTS],
	input  regval_pkg::reg_mask_t livetarget,
	input  logic                  branchmiss,
	input  regval_pkg::reg_mask_t rf_v,
	input  regval_pkg::reg_mask_t reg_is_valid,
	input  regval_pkg::operand_t  operands [2*`REGVAL_QSLOTS],
	output int                    error_count,
	output int                    checked_count
);
	import regval_pkg::*;

	// model state as it stands after the most recent rising edge
	reg_mask_t m_valid;
	rob_tag_t  m_src [`REGVAL_AREGS];

	// ==========================================================================
	// compare at the falling edge, where inputs and outputs are settled
	// ==========================================================================

	always @(negedge clk) begin : compare
		reg_mask_t exp_adv;
		reg_mask_t claimed;
		rob_tag_t  claim_tag [`REGVAL_AREGS];
		reg_idx_t  r;
		logic      exp_ready;
		rob_tag_t  exp_tag;
		if (rst) begin
			// the coming edge resets the DUT, so the model follows it
			m_valid = '1;
			for (int n = 0; n < `REGVAL_AREGS; n++) begin
				m_src[n] = '0;
			end
		end else begin
			// hold, then restore on a branch miss, then the commit ports in order
			for (int n = 0; n < `REGVAL_AREGS; n++) begin
				exp_adv[n] = m_valid[n];
				if (branchmiss && !livetarget[n]) begin
					exp_adv[n] = 1'b1;
				end
				for (int p = 0; p < `REGVAL_CPORTS; p++) begin
					if (commits[p].v && commits[p].rfw && int'(commits[p].tgt) == n &&
						!m_valid[n]) begin
						exp_adv[n] = (commits[p].id == m_src[n]);
					end
				end
				claim_tag[n] = '0;
			end
			// walking the slots in order lets the youngest claim win
			claimed = '0;
			for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
				if (slots[s].v && slots[s].rfw && !branchmiss) begin
					claimed[slots[s].rd]   = 1'b1;
					claim_tag[slots[s].rd] = slots[s].tag;
				end
			end
			if (rf_v !== m_valid) begin
				$display("Mismatch at %0t: rf_v is %b, expected %b", $time, rf_v, m_valid);
				error_count++;
			end
			if (reg_is_valid !== exp_adv) begin
				$display("Mismatch at %0t: reg_is_valid is %b, expected %b",
					$time, reg_is_valid, exp_adv);
				error_count++;
			end
			// lookups, slot-major with rs1 first
			for (int k = 0; k < 2*`REGVAL_QSLOTS; k++) begin
				r         = (k % 2 == 0) ? slots[k/2].rs1 : slots[k/2].rs2;
				exp_ready = exp_adv[r];
				exp_tag   = m_src[r];
				for (int e = 0; e < k/2; e++) begin
					if (slots[e].v && slots[e].rfw && !branchmiss && slots[e].rd == r) begin
						exp_ready = 1'b0;
						exp_tag   = slots[e].tag;
					end
				end
				// the tag only carries meaning while the operand waits
				// a lookup result is shown as ready/tag
				if (operands[k].ready !== exp_ready ||
					(!exp_ready && operands[k].tag !== exp_tag)) begin
					$display("Mismatch at %0t: operand %0d is %b/%0d, expected %b/%0d",
						$time, k, operands[k].ready, operands[k].tag, exp_ready, exp_tag);
					error_count++;
				end
			end
			// a claim overrides whatever the restore or commits produced
			for (int n = 0; n < `REGVAL_AREGS; n++) begin
				m_valid[n] = claimed[n] ? 1'b0 : exp_adv[n];
				if (claimed[n]) begin
					m_src[n] = claim_tag[n];
				end
			end
			checked_count++;
		end
	end

endmodule

/* bench/regval_properties.sv */
// concurrent checks on the valid vectors of the scoreboard, bound into regval_top by the testbench
`timescale 1ns/1ns
`include "regval_settings.svh"

module regval_properties (
	input logic                  clk,
	input logic                  rst,
	input regval_pkg::reg_mask_t rf_v,
	input regval_pkg::reg_mask_t reg_is_valid,
	input regval_pkg::claim_t    claims [`REGVAL_AREGS]
);
	import regval_pkg::*;

	// failures per assertion, read by the testbench at the end of the run
	int reset_fails;
	int claim_fails;
	int adv_fails;

	// registers that are claimed in this cycle
	reg_mask_t claim_mask;

	always_comb begin
		for (int n = 0; n < `REGVAL_AREGS; n++) begin
			claim_mask[n] = claims[n].hit;
		end
	end

	// ==========================================================================
	// assertions
	// ==========================================================================

	// reset leaves every register valid
	a_reset_valid: assert property (@(posedge clk) rst |=> (rf_v == '1))
		else begin
			$error("rf_v is not all ones in the cycle after reset");
			reset_fails++;
		end

	// a claimed register has dropped its valid bit by the next edge
	a_claim_clears: assert property (@(posedge clk) disable iff (rst)
		(claim_mask != '0) |=> ((rf_v & $past(claim_mask)) == '0))
		else begin
			$error("a claimed register is still valid in the next cycle");
			claim_fails++;
		end

	// restores and commits only raise bits, so the advance vector may only
	// sit below rf_v on a register that is claimed
	a_adv_covers: assert property (@(posedge clk) disable iff (rst)
		((rf_v & ~reg_is_valid & ~claim_mask) == '0))
		else begin
			$error("reg_is_valid is low on a valid register without a claim");
			adv_fails++;
		end

endmodule

/* rtl/regval_top.sv */
// top level of the register-valid scoreboard, joining the claim decoder, the trackers and the lookups
`timescale 1ns/1ns
`include "regval_settings.svh"

module regval_top (
	input  logic                  clk,
	input  logic                  rst,
	input  regval_pkg::slot_t     slots [`REGVAL_QSLOTS],
	input  regval_pkg::commit_t   commits [`REGVAL_CPORTS],
	input  regval_pkg::reg_mask_t livetarget,
	input  logic                  branchmiss,
	output regval_pkg::reg_mask_t rf_v,
	output regval_pkg::reg_mask_t reg_is_valid,
	output regval_pkg::operand_t  operands [2*`REGVAL_QSLOTS]
);
	import regval_pkg::*;

	// winning claim on each register in this cycle
	claim_t claims [`REGVAL_AREGS];

	// per-tracker outputs before they are packed into masks
	logic trk_valid [`REGVAL_AREGS];
	logic trk_adv [`REGVAL_AREGS];

	// recorded producer of every register
	rob_tag_t rf_source [`REGVAL_AREGS];

	// ==========================================================================
	// claim decode
	// ==========================================================================

	dispatch_decode i_dispatch_decode (
		.slots      (slots),
		.branchmiss (branchmiss),
		.claims     (claims)
	);

	// ==========================================================================
	// one tracker per architectural register
	// ==========================================================================

	// each tracker sees every commit port and picks out its own target
	for (genvar n = 0; n < `REGVAL_AREGS; n++) begin : g_track
		reg_track #(
			.REG_INDEX (n)
		) i_reg_track (
			.clk        (clk),
			.rst        (rst),
			.claim      (claims[n]),
			.commits    (commits),
			.branchmiss (branchmiss),
			.live       (livetarget[n]),
			.valid      (trk_valid[n]),
			.valid_adv  (trk_adv[n]),
			.source     (rf_source[n])
		);
	end

	// gather the tracker bits into the registered and advance valid vectors
	always_comb begin
		for (int n = 0; n < `REGVAL_AREGS; n++) begin
			rf_v[n]         = trk_valid[n];
			reg_is_valid[n] = trk_adv[n];
		end
	end

	// ==========================================================================
	// operand lookups
	// ==========================================================================

	// lookups use the advance vector so a matching commit in this cycle
	// already makes the operand ready
	operand_lookup i_operand_lookup (
		.slots      (slots),
		.branchmiss (branchmiss),
		.reg_valid  (reg_is_valid),
		.sources    (rf_source),
		.operands   (operands)
	);

endmodule

/* rtl/operand_lookup.sv */
// answers the two source lookups of every queue slot from the trackers and the same-group writers
`timescale 1ns/1ns
`include "regval_settings.svh"

module operand_lookup (
	input  regval_pkg::slot_t     slots [`REGVAL_QSLOTS],
	input  logic                  branchmiss,
	input  regval_pkg::reg_mask_t reg_valid,
	input  regval_pkg::rob_tag_t  sources [`REGVAL_AREGS],
	output regval_pkg::operand_t  operands [2*`REGVAL_QSLOTS]
);
	import regval_pkg::*;

	// source register of every lookup, slot-major with rs1 before rs2
	reg_idx_t src_reg [2*`REGVAL_QSLOTS];

	// slot s writes a register and may feed a younger slot of the group
	logic [`REGVAL_QSLOTS-1:0] group_wr;

	// per lookup, the earlier slots that write its source register
	logic [`REGVAL_QSLOTS-1:0] fwd_hit [2*`REGVAL_QSLOTS];

	// ==========================================================================
	// lookup list and writer qualification
	// ==========================================================================

	always_comb begin
		for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
			src_reg[2*s]   = slots[s].rs1;
			src_reg[2*s+1] = slots[s].rs2;
			// during a branch miss the group is dropped, so nothing forwards
			group_wr[s]    = slots[s].v && slots[s].rfw && !branchmiss;
		end
	end

	// a lookup of slot k/2 may only see slots that are older than itself
	always_comb begin
		for (int k = 0; k < 2*`REGVAL_QSLOTS; k++) begin
			for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
				fwd_hit[k][s] = (s < k/2) && group_wr[s] &&
					(slots[s].rd == src_reg[k]);
			end
		end
	end

	// ==========================================================================
	// result selection
	// ==========================================================================

	// start from the tracker, using the advance valid so that a commit in
	// this cycle already counts, then let each earlier writer override it
	// from oldest to youngest so the youngest writer's tag is kept
	always_comb begin
		for (int k = 0; k < 2*`REGVAL_QSLOTS; k++) begin
			operands[k].ready = reg_valid[src_reg[k]];
			operands[k].tag   = sources[src_reg[k]];
			for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
				if (fwd_hit[k][s]) begin
					operands[k].ready = 1'b0;
					operands[k].tag   = slots[s].tag;
				end
			end
		end
	end

	// the lookups of slot 0 never forward since no older slot exists

	// the lookup is answered whether or not the slot is valid, and the
	// consumer is expected to ignore the results of empty slots

	// the source tag is passed through even when ready is high, where it
	// just names the last producer of the register

endmodule

/* rtl/reg_track.sv */
// valid bit and producer tag of one architectural register, instantiated once per register
`timescale 1ns/1ns
`include "regval_settings.svh"

module reg_track #(
	parameter int REG_INDEX = 0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  regval_pkg::claim_t   claim,
	input  regval_pkg::commit_t  commits [`REGVAL_CPORTS],
	input  logic                 branchmiss,
	input  logic                 live,
	output logic                 valid,
	output logic                 valid_adv,
	output regval_pkg::rob_tag_t source
);
	import regval_pkg::*;

	// commit port p targets this register with a register write
	logic [`REGVAL_CPORTS-1:0] cm_hit;

	// commit port p carries the tag of the current producer
	logic [`REGVAL_CPORTS-1:0] cm_match;

	// state to be loaded at the next edge
	logic     valid_next;
	rob_tag_t source_next;

	// ==========================================================================
	// commit selection
	// ==========================================================================

	// the producer of this register may have been replaced by a newer claim
	// after the result went onto the commit bus, so the id has to match the
	// recorded source before the register can be made valid
	always_comb begin
		for (int p = 0; p < `REGVAL_CPORTS; p++) begin
			cm_hit[p]   = commits[p].v && commits[p].rfw &&
				(commits[p].tgt == reg_idx_t'(REG_INDEX));
			cm_match[p] = (commits[p].id == source);
		end
	end

	// ==========================================================================
	// advance valid, used by the read-through register file
	// ==========================================================================

	// hold, then branch-miss restore, then the commit ports in order
	// a later port overrides the result of an earlier one
	always_comb begin
		valid_adv = valid;
		if (branchmiss && !live) begin
			valid_adv = 1'b1;
		end
		for (int p = 0; p < `REGVAL_CPORTS; p++) begin
			// only a register that is not valid at the start of the cycle listens
			if (cm_hit[p] && !valid) begin
				valid_adv = cm_match[p];
			end
		end
	end

	// ==========================================================================
	// next state and storage
	// ==========================================================================

	// a claim in this cycle wins over any restore or commit result
	always_comb begin
		valid_next  = valid_adv;
		source_next = source;
		if (claim.hit) begin
			valid_next  = 1'b0;
			source_next = claim.tag;
		end
	end

	// out of reset every register is valid and owned by tag zero
	always_ff @(posedge clk) begin
		if (rst) begin
			valid  <= 1'b1;
			source <= '0;
		end else begin
			valid  <= valid_next;
			source <= source_next;
		end
	end

endmodule

/* rtl/dispatch_decode.sv */
// turns the queued slots of one cycle into a single claim per register, the latest slot winning
`timescale 1ns/1ns
`include "regval_settings.svh"

module dispatch_decode (
	input  regval_pkg::slot_t  slots [`REGVAL_QSLOTS],
	input  logic               branchmiss,
	output regval_pkg::claim_t claims [`REGVAL_AREGS]
);
	import regval_pkg::*;

	// a slot takes over its destination only when it holds a writing instruction
	// and no branch miss is flushing this group
	logic [`REGVAL_QSLOTS-1:0] slot_wr;

	// one-hot decode of every slot's destination, already qualified by slot_wr
	reg_mask_t rd_hit [`REGVAL_QSLOTS];

	// ==========================================================================
	// per-slot write qualification and destination decode
	// ==========================================================================

	always_comb begin
		for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
			slot_wr[s] = slots[s].v && slots[s].rfw && !branchmiss;
		end
	end

	always_comb begin
		for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
			rd_hit[s] = '0;
			for (int r = 0; r < `REGVAL_AREGS; r++) begin
				// compare against the register index as a full reg_idx_t
				if (slots[s].rd == reg_idx_t'(r)) begin
					rd_hit[s][r] = slot_wr[s];
				end
			end
		end
	end

	// ==========================================================================
	// claim selection per register
	// ==========================================================================

	// the slots are scanned from oldest to youngest, so a later hit simply
	// overwrites an earlier one and the highest slot number wins
	always_comb begin
		for (int r = 0; r < `REGVAL_AREGS; r++) begin
			claims[r].hit = 1'b0;
			claims[r].tag = '0;
			for (int s = 0; s < `REGVAL_QSLOTS; s++) begin
				if (rd_hit[s][r]) begin
					claims[r].hit = 1'b1;
					claims[r].tag = slots[s].tag;
				end
			end
		end
	end

	// with branchmiss high every slot_wr bit is low, so no register is claimed
	// and the trackers can ignore branchmiss when they look at a claim

	// an unclaimed register carries a zero tag, which the tracker never
	// loads because hit is low

	// a slot that is valid but does not write a register never claims,
	// even though its rd field may hold any value

endmodule

/* rtl/regval_pkg.sv */
// shared vector types and packed structs of the register-valid scoreboard, imported by RTL and bench
`include "regval_settings.svh"

package regval_pkg;

	// ======================================================================
	// plain vectors with a meaning
	// ======================================================================

	// names one architectural register
	typedef logic [`REGVAL_REG_W-1:0] reg_idx_t;

	// names one producing instruction in the ROB
	typedef logic [`REGVAL_TAG_W-1:0] rob_tag_t;

	// one bit per architectural register
	typedef logic [`REGVAL_AREGS-1:0] reg_mask_t;

	// ======================================================================
	// bundles that travel together
	// ======================================================================

	// one instruction in a queue slot of the current group
	typedef struct packed {
		logic     v;
		logic     rfw;
		reg_idx_t rd;
		rob_tag_t tag;
		reg_idx_t rs1;
		reg_idx_t rs2;
	} slot_t;

	// one result reported on a commit port
	typedef struct packed {
		logic     v;
		logic     rfw;
		reg_idx_t tgt;
		rob_tag_t id;
	} commit_t;

	// the winning claim on one register in this cycle
	typedef struct packed {
		logic     hit;
		rob_tag_t tag;
	} claim_t;

	// the answer to one operand lookup
	// tag only matters while ready is low
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
	} operand_t;

endpackage

/* include/regval_settings.svh */
// sizing macros of the register-valid scoreboard, included by the package and every RTL module
`ifndef REGVAL_SETTINGS_SVH
`define REGVAL_SETTINGS_SVH

// ==========================================================================
// scoreboard dimensions
// ==========================================================================

// number of architectural registers tracked by the scoreboard
`define REGVAL_AREGS 8
// instructions queued per cycle by the front end
`define REGVAL_QSLOTS 3
// result ports coming back from the ROB each cycle
`define REGVAL_CPORTS 3
// width of a ROB tag, so sixteen entries in flight
`define REGVAL_TAG_W 4
// width of an architectural register index
`define REGVAL_REG_W 3

`endif
